// ==== test/cpu_stimulus.txt ====
# I addr word = reachable instruction, X addr word = skipped instruction, D addr word = data
# S addr byte_enables data = expected store in order, H = expected halt on ebreak
D 200 80F17F85
I 000 123450B7
I 004 67808093
I 008 10102023
I 00C FFB00113
I 010 40115193
I 014 01C15213
I 018 404182B3
I 01C 10502223
I 020 00412333
I 024 004133B3
I 028 00431413
I 02C 0080C4B3
I 030 10902423
I 034 00001517
I 038 10A02623
I 03C 20000583
I 040 20104603
I 044 20201683
I 048 20005703
I 04C 10B008A3
I 050 10C009A3
I 054 10D01B23
I 058 10E01C23
I 05C 20002783
I 060 10F02E23
I 064 00630463
X 068 1E002823
I 06C 00631463
I 070 12602023
I 074 00414463
X 078 1E002823
I 07C 00416463
I 080 12402223
I 084 00225463
X 088 1E002823
I 08C 00227463
I 090 00C0086F
X 094 1E002823
X 098 1E002823
I 09C 13002423
I 0A0 015808E7
X 0A4 1E002823
I 0A8 13102623
I 0AC 00100073
S 100 F 12345678
S 104 F FFFFFFEE
S 108 F 12345668
S 10C F 00001034
S 110 2 FFFF8500
S 110 8 7F000000
S 114 C 80F10000
S 118 3 00007F85
S 11C F 80F17F85
S 120 F 00000001
S 124 F 0000000F
S 128 F 00000094
S 12C F 000000A4
H

// ==== rv_multicycle.f ====
+incdir+common
common/rv_pkg.sv
common/dmem_if.sv
src/reg_file.sv
src/decoder.sv
src/alu.sv
src/load_store.sv
control/cpu_control.sv
src/cpu_core.sv
test/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_multicycle testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f rv_multicycle.f --top-module tb_cpu_core -o tb_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_cpu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== test/tb_cpu_core.sv ====
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_cpu_core;

    localparam int CLK_PERIOD = 100;

    logic                clk;
    logic                rstn;
    logic                imem_req;
    rv_pkg::iaddr_t      imem_addr;
    logic                imem_ack;
    rv_pkg::word_t       imem_rdata;
    logic                dmem_req;
    rv_pkg::daddr_t      dmem_addr;
    rv_pkg::word_t       dmem_wdata;
    rv_pkg::byte_en_t    dmem_be;
    logic                dmem_ack;
    rv_pkg::word_t       dmem_rdata;
    logic                halted;

    // memory models, one word per entry
    logic [31:0] imem [1024];
    logic        reach [1024];
    logic [31:0] dmem [1024];

    // expected store records in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_be [$];
    logic [31:0] exp_data [$];
    logic        halt_expected;
    int          instr_count;
    logic        loaded;
    logic        first_fetch;

    cpu_core dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("[ERROR] %s expected 0x%h actual 0x%h", name, expv, actv);
        stop_with_failure();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        logic [63:0] tag;
        logic [2047:0] line;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] b;
        fd = $fopen("test/cpu_stimulus.txt", "r");
        assert (fd != 0) else abort_run("cannot open test/cpu_stimulus.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
                if (tag == "#") begin
                    n = $fgets(line, fd);
                end else if (tag == "I" || tag == "X") begin
                    n = $fscanf(fd, "%h %h", a, w);
                    imem[a[11:2]] = w;
                    // X words sit on a path the program must skip
                    reach[a[11:2]] = (tag == "I");
                    instr_count++;
                end else if (tag == "D") begin
                    n = $fscanf(fd, "%h %h", a, w);
                    dmem[a[11:2]] = w;
                end else if (tag == "S") begin
                    n = $fscanf(fd, "%h %h %h", a, b, w);
                    exp_addr.push_back(a);
                    exp_be.push_back(b);
                    exp_data.push_back(w);
                end else if (tag == "H") begin
                    halt_expected = 1'b1;
                end else begin
                    abort_run("unknown record tag in stimulus file");
                end
            end
        end
        $fclose(fd);
    endtask

    // instruction memory, random latency per fetch
    initial begin
        int lat;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && imem_req) begin
                assert (!halted) else abort_run("fetch request after halt");
                if (first_fetch) begin
                    assert (imem_addr == `RV_RESET_PC)
                        else report_mismatch("imem_addr", 32'(`RV_RESET_PC), 32'(imem_addr));
                    first_fetch = 1'b0;
                end
                assert (reach[imem_addr[11:2]] === 1'b1)
                    else abort_run("fetch from an address the program cannot reach");
                lat = $urandom_range(4, 1);
                repeat (lat) @(posedge clk);
                #1;
                imem_ack   = 1'b1;
                imem_rdata = imem[imem_addr[11:2]];
                @(posedge clk);
                #1;
                imem_ack = 1'b0;
            end
        end
    end

    // data memory, checks every store against the next record
    initial begin
        int lat;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && dmem_req) begin
                if (dmem_be != 4'b0000) begin
                    assert (exp_addr.size() > 0)
                        else abort_run("store seen with no expected record left");
                    assert (dmem_addr == exp_addr[0][11:0])
                        else report_mismatch("dmem_addr", exp_addr[0], 32'(dmem_addr));
                    assert (dmem_be == exp_be[0][3:0])
                        else report_mismatch("dmem_be", exp_be[0], 32'(dmem_be));
                    assert (dmem_wdata == exp_data[0])
                        else report_mismatch("dmem_wdata", exp_data[0], dmem_wdata);
                    void'(exp_addr.pop_front());
                    void'(exp_be.pop_front());
                    void'(exp_data.pop_front());
                    for (int k = 0; k < 4; k++) begin
                        if (dmem_be[k]) begin
                            dmem[dmem_addr[11:2]][8*k +: 8] = dmem_wdata[8*k +: 8];
                        end
                    end
                end
                lat = $urandom_range(4, 1);
                repeat (lat) @(posedge clk);
                #1;
                dmem_ack   = 1'b1;
                dmem_rdata = dmem[dmem_addr[11:2]];
                @(posedge clk);
                #1;
                dmem_ack = 1'b0;
            end
        end
    end

    // watchdog, 200 cycles per program word
    initial begin
        wait (loaded === 1'b1);
        #(instr_count * 200 * CLK_PERIOD);
        abort_run("timeout: core did not reach ebreak in time");
    end

    initial begin
        void'($urandom(32'h11ea6257));
        rstn          = 1'b0;
        imem_ack      = 1'b0;
        imem_rdata    = '0;
        dmem_ack      = 1'b0;
        dmem_rdata    = '0;
        halt_expected = 1'b0;
        instr_count   = 0;
        loaded        = 1'b0;
        first_fetch   = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[i]  = 32'h0;
            reach[i] = 1'b0;
            dmem[i]  = 32'hc0de0000 | 32'(i << 2);
        end
        load_stimulus();
        loaded = 1'b1;

        repeat (16) @(posedge clk);
        #1;
        assert (imem_req == 1'b0) else report_mismatch("imem_req", 32'h0, 32'(imem_req));
        assert (dmem_req == 1'b0) else report_mismatch("dmem_req", 32'h0, 32'(dmem_req));
        assert (halted == 1'b0) else report_mismatch("halted", 32'h0, 32'(halted));
        rstn = 1'b1;

        wait (halted === 1'b1);
        assert (halt_expected) else abort_run("core halted but no halt was expected");
        assert (exp_addr.size() == 0)
            else abort_run("core halted before all expected stores appeared");
        // idle a while so a stray fetch would be caught
        repeat (20) @(posedge clk);
        assert (halted === 1'b1) else report_mismatch("halted", 32'h1, 32'(halted));
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic                clk,
    input  logic                rstn,
    // instruction memory
    output logic                imem_req,
    output rv_pkg::iaddr_t      imem_addr,
    input  logic                imem_ack,
    input  rv_pkg::word_t       imem_rdata,
    // data memory
    output logic                dmem_req,
    output rv_pkg::daddr_t      dmem_addr,
    output rv_pkg::word_t       dmem_wdata,
    output rv_pkg::byte_en_t    dmem_be,
    input  logic                dmem_ack,
    input  rv_pkg::word_t       dmem_rdata,
    output logic                halted
);

    rv_pkg::reg_addr_t rf_raddr1;
    rv_pkg::reg_addr_t rf_raddr2;
    rv_pkg::word_t     rf_rdata1;
    rv_pkg::word_t     rf_rdata2;
    logic              rf_we;
    rv_pkg::reg_addr_t rf_waddr;
    rv_pkg::word_t     rf_wdata;

    rv_pkg::word_t     instr;
    rv_pkg::iaddr_t    pc;

    // decoder outputs
    rv_pkg::reg_addr_t dec_rd;
    rv_pkg::word_t     dec_imm;
    rv_pkg::funct3_t   dec_funct3;
    logic              dec_alu_alt;
    logic              is_alu;
    logic              is_lui;
    logic              is_auipc;
    logic              is_jal;
    logic              is_jalr;
    logic              is_branch;
    logic              is_load;
    logic              is_store;
    logic              is_halt;
    rv_pkg::word_t     dec_op_a;
    rv_pkg::word_t     dec_op_b;

    // alu inputs come from the stage registers
    rv_pkg::funct3_t   alu_funct3;
    logic              alu_alt;
    rv_pkg::word_t     alu_a;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     cmp_a;
    rv_pkg::word_t     cmp_b;
    rv_pkg::word_t     alu_result;
    logic              branch_taken;

    dmem_if mem_bus ();

    cpu_control control0 (
        .clk          (clk),
        .rstn         (rstn),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .halted       (halted),
        .is_alu       (is_alu),
        .is_lui       (is_lui),
        .is_auipc     (is_auipc),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .is_branch    (is_branch),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_halt      (is_halt),
        .rd           (dec_rd),
        .imm          (dec_imm),
        .funct3       (dec_funct3),
        .alu_alt      (dec_alu_alt),
        .op_a         (dec_op_a),
        .op_b         (dec_op_b),
        .rs1_data     (rf_rdata1),
        .rs2_data     (rf_rdata2),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .alu_funct3   (alu_funct3),
        .alu_alt_q    (alu_alt),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .cmp_a        (cmp_a),
        .cmp_b        (cmp_b),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .instr        (instr),
        .pc           (pc),
        .mem          (mem_bus.ctrl)
    );

    reg_file reg_file0 (
        .clk    (clk),
        .rstn   (rstn),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    decoder decoder0 (
        .instr     (instr),
        .pc        (pc),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .funct3    (dec_funct3),
        .alu_alt   (dec_alu_alt),
        .is_alu    (is_alu),
        .is_lui    (is_lui),
        .is_auipc  (is_auipc),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .is_branch (is_branch),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_halt   (is_halt),
        .op_a      (dec_op_a),
        .op_b      (dec_op_b)
    );

    alu alu0 (
        .funct3       (alu_funct3),
        .alu_alt      (alu_alt),
        .op_a         (alu_a),
        .op_b         (alu_b),
        .cmp_a        (cmp_a),
        .cmp_b        (cmp_b),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    load_store load_store0 (
        .clk        (clk),
        .rstn       (rstn),
        .lsu        (mem_bus.lsu),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

endmodule

// ==== control/cpu_control.sv ====
`timescale 1ns/1ps

`include "rv_params.svh"

module cpu_control (
    input  logic                clk,
    input  logic                rstn,
    // fetch port
    input  logic                imem_ack,
    input  rv_pkg::word_t       imem_rdata,
    output logic                imem_req,
    output rv_pkg::iaddr_t      imem_addr,
    output logic                halted,
    // decoded instruction
    input  logic                is_alu,
    input  logic                is_lui,
    input  logic                is_auipc,
    input  logic                is_jal,
    input  logic                is_jalr,
    input  logic                is_branch,
    input  logic                is_load,
    input  logic                is_store,
    input  logic                is_halt,
    input  rv_pkg::reg_addr_t   rd,
    input  rv_pkg::word_t       imm,
    input  rv_pkg::funct3_t     funct3,
    input  logic                alu_alt,
    input  rv_pkg::word_t       op_a,
    input  rv_pkg::word_t       op_b,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    // alu
    input  rv_pkg::word_t       alu_result,
    input  logic                branch_taken,
    output rv_pkg::funct3_t     alu_funct3,
    output logic                alu_alt_q,
    output rv_pkg::word_t       alu_a,
    output rv_pkg::word_t       alu_b,
    output rv_pkg::word_t       cmp_a,
    output rv_pkg::word_t       cmp_b,
    // register write port
    output logic                rf_we,
    output rv_pkg::reg_addr_t   rf_waddr,
    output rv_pkg::word_t       rf_wdata,
    // fetched instruction for the decoder
    output rv_pkg::word_t       instr,
    output rv_pkg::iaddr_t      pc,
    dmem_if.ctrl                mem
);

    rv_pkg::ctrl_state_t state;

    // decode to execute stage
    logic              alu_q;
    logic              lui_q;
    logic              auipc_q;
    logic              jal_q;
    logic              jalr_q;
    logic              branch_q;
    logic              load_q;
    logic              store_q;
    logic              halt_q;
    rv_pkg::reg_addr_t rd_q;
    rv_pkg::word_t     imm_q;
    rv_pkg::funct3_t   funct3_q;

    // execute to write-back
    logic              wen_q;
    rv_pkg::word_t     wb_q;
    rv_pkg::iaddr_t    next_pc_q;

    rv_pkg::iaddr_t    pc_plus4;

    assign pc_plus4  = pc + rv_pkg::iaddr_t'(4);
    assign imem_addr = pc;
    assign halted    = (state == rv_pkg::st_halt);

    // register write only in the write-back cycle
    assign rf_we    = (state == rv_pkg::st_write) && wen_q;
    assign rf_waddr = rd_q;
    assign rf_wdata = wb_q;

    // state, pc and the request strobes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= rv_pkg::st_fetch;
            pc        <= `RV_RESET_PC;
            imem_req  <= 1'b0;
            mem.start <= 1'b0;
        end else begin
            imem_req  <= 1'b0;
            mem.start <= 1'b0;
            case (state)
                rv_pkg::st_fetch: begin
                    imem_req <= 1'b1;
                    state    <= rv_pkg::st_fetch_wait;
                end
                rv_pkg::st_fetch_wait: begin
                    if (imem_ack) begin
                        state <= rv_pkg::st_decode;
                    end
                end
                rv_pkg::st_decode: begin
                    state <= rv_pkg::st_execute;
                end
                rv_pkg::st_execute: begin
                    if (load_q || store_q) begin
                        mem.start <= 1'b1;
                        state     <= rv_pkg::st_mem_wait;
                    end else if (halt_q) begin
                        state <= rv_pkg::st_halt;
                    end else begin
                        state <= rv_pkg::st_write;
                    end
                end
                rv_pkg::st_mem_wait: begin
                    if (mem.done) begin
                        state <= rv_pkg::st_write;
                    end
                end
                rv_pkg::st_write: begin
                    pc    <= next_pc_q;
                    state <= rv_pkg::st_fetch;
                end
                default: begin
                    state <= rv_pkg::st_halt;
                end
            endcase
        end
    end

    // datapath registers, loaded by state
    always_ff @(posedge clk) begin
        case (state)
            rv_pkg::st_fetch_wait: begin
                if (imem_ack) begin
                    instr <= imem_rdata;
                end
            end
            rv_pkg::st_decode: begin
                alu_q      <= is_alu;
                lui_q      <= is_lui;
                auipc_q    <= is_auipc;
                jal_q      <= is_jal;
                jalr_q     <= is_jalr;
                branch_q   <= is_branch;
                load_q     <= is_load;
                store_q    <= is_store;
                halt_q     <= is_halt;
                rd_q       <= rd;
                imm_q      <= imm;
                funct3_q   <= funct3;
                // address, jalr and auipc sums all use add
                alu_funct3 <= (is_alu || is_branch) ? funct3 : 3'b000;
                alu_alt_q  <= alu_alt;
                alu_a      <= op_a;
                alu_b      <= op_b;
                cmp_a      <= rs1_data;
                cmp_b      <= rs2_data;
            end
            rv_pkg::st_execute: begin
                wen_q        <= alu_q || lui_q || auipc_q || jal_q || jalr_q || load_q;
                mem.is_store <= store_q;
                mem.funct3   <= funct3_q;
                mem.addr     <= rv_pkg::daddr_t'(alu_result);
                mem.wdata    <= cmp_b;
                if (lui_q) begin
                    wb_q <= imm_q;
                end else if (jal_q || jalr_q) begin
                    wb_q <= rv_pkg::word_t'(pc_plus4);
                end else begin
                    wb_q <= alu_result;
                end
                if (jal_q || (branch_q && branch_taken)) begin
                    next_pc_q <= pc + rv_pkg::iaddr_t'(imm_q);
                end else if (jalr_q) begin
                    next_pc_q <= rv_pkg::iaddr_t'(alu_result) & ~rv_pkg::iaddr_t'(1);
                end else begin
                    next_pc_q <= pc_plus4;
                end
            end
            rv_pkg::st_mem_wait: begin
                if (mem.done && load_q) begin
                    wb_q <= mem.rdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== src/load_store.sv ====
`timescale 1ns/1ps

module load_store (
    input  logic             clk,
    input  logic             rstn,
    dmem_if.lsu              lsu,
    output logic             dmem_req,
    output rv_pkg::daddr_t   dmem_addr,
    output rv_pkg::word_t    dmem_wdata,
    output rv_pkg::byte_en_t dmem_be,
    input  logic             dmem_ack,
    input  rv_pkg::word_t    dmem_rdata
);

    logic [1:0]       off;
    rv_pkg::byte_en_t be;

    // kept for the load return
    logic [1:0]       off_q;
    rv_pkg::funct3_t  funct3_q;
    rv_pkg::word_t    lane_data;

    assign off = lsu.addr[1:0];

    always_comb begin
        case (lsu.funct3[1:0])
            2'b00:   be = 4'b0001 << off;
            2'b01:   be = 4'b0011 << off;
            default: be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dmem_req <= 1'b0;
        end else begin
            dmem_req <= lsu.start;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu.start) begin
            dmem_addr  <= {lsu.addr[$bits(rv_pkg::daddr_t)-1:2], 2'b00};
            dmem_wdata <= lsu.wdata << {off, 3'b000};
            dmem_be    <= lsu.is_store ? be : 4'b0000;
            off_q      <= off;
            funct3_q   <= lsu.funct3;
        end
    end

    // addressed byte or halfword moved down to bit 0
    assign lane_data = dmem_rdata >> {off_q, 3'b000};

    always_comb begin
        case (funct3_q)
            3'b000:  lsu.rdata = {{24{lane_data[7]}}, lane_data[7:0]};
            3'b001:  lsu.rdata = {{16{lane_data[15]}}, lane_data[15:0]};
            3'b100:  lsu.rdata = {24'b0, lane_data[7:0]};
            3'b101:  lsu.rdata = {16'b0, lane_data[15:0]};
            default: lsu.rdata = dmem_rdata;
        endcase
    end

    assign lsu.done = dmem_ack;

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::funct3_t funct3,
    input  logic            alu_alt,
    input  rv_pkg::word_t   op_a,
    input  rv_pkg::word_t   op_b,
    input  rv_pkg::word_t   cmp_a,
    input  rv_pkg::word_t   cmp_b,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (funct3)
            3'b000:  result = alu_alt ? op_a - op_b : op_a + op_b;
            3'b001:  result = op_a << shamt;
            3'b010:  result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            3'b011:  result = rv_pkg::word_t'(op_a < op_b);
            3'b100:  result = op_a ^ op_b;
            3'b101:  result = alu_alt ? rv_pkg::word_t'($signed(op_a) >>> shamt)
                                      : op_a >> shamt;
            3'b110:  result = op_a | op_b;
            default: result = op_a & op_b;
        endcase
    end

    // branch compare works on the register values, not the operands
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (cmp_a == cmp_b);
            3'b001:  branch_taken = (cmp_a != cmp_b);
            3'b100:  branch_taken = ($signed(cmp_a) < $signed(cmp_b));
            3'b101:  branch_taken = ($signed(cmp_a) >= $signed(cmp_b));
            3'b110:  branch_taken = (cmp_a < cmp_b);
            3'b111:  branch_taken = (cmp_a >= cmp_b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

`include "rv_params.svh"

module decoder (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::iaddr_t    pc,
    input  rv_pkg::word_t     rdata1,
    input  rv_pkg::word_t     rdata2,
    output rv_pkg::reg_addr_t raddr1,
    output rv_pkg::reg_addr_t raddr2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::funct3_t   funct3,
    output logic              alu_alt,
    output logic              is_alu,
    output logic              is_lui,
    output logic              is_auipc,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_branch,
    output logic              is_load,
    output logic              is_store,
    output logic              is_halt,
    output rv_pkg::word_t     op_a,
    output rv_pkg::word_t     op_b
);

    logic [6:0]    opcode;
    logic          is_alui;
    logic          use_imm;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // instruction class, is_alu covers register and immediate forms
    assign is_alu    = (opcode == `RV_OP_ALU) || is_alui;
    assign is_alui   = (opcode == `RV_OP_ALUI);
    assign is_lui    = (opcode == `RV_OP_LUI);
    assign is_auipc  = (opcode == `RV_OP_AUIPC);
    assign is_jal    = (opcode == `RV_OP_JAL);
    assign is_jalr   = (opcode == `RV_OP_JALR);
    assign is_branch = (opcode == `RV_OP_BRANCH);
    assign is_load   = (opcode == `RV_OP_LOAD);
    assign is_store  = (opcode == `RV_OP_STORE);
    // ebreak only, other system opcodes run as no-ops
    assign is_halt   = (opcode == `RV_OP_SYSTEM) && (instr[31:7] == 25'h0002000);

    always_comb begin
        if (is_store) begin
            imm = imm_s;
        end else if (is_branch) begin
            imm = imm_b;
        end else if (is_lui || is_auipc) begin
            imm = imm_u;
        end else if (is_jal) begin
            imm = imm_j;
        end else begin
            imm = imm_i;
        end
    end

    // sub and sra need funct7 bit 5; addi has no such bit
    assign alu_alt = ((opcode == `RV_OP_ALU) || (is_alui && funct3 == 3'b101)) ? instr[30]
                                                                              : 1'b0;

    assign use_imm = is_alui || is_load || is_store || is_jalr || is_auipc;
    assign op_a    = is_auipc ? rv_pkg::word_t'(pc) : rdata1;
    assign op_b    = use_imm ? imm : rdata2;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rstn,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== common/dmem_if.sv ====
`timescale 1ns/1ps

interface dmem_if;

    // request, valid for the one cycle that start is high
    logic            start;
    logic            is_store;
    rv_pkg::funct3_t funct3;
    rv_pkg::daddr_t  addr;
    rv_pkg::word_t   wdata;

    // response, rdata already extended
    logic            done;
    rv_pkg::word_t   rdata;

    modport ctrl (
        output start, is_store, funct3, addr, wdata,
        input  done, rdata
    );

    modport lsu (
        input  start, is_store, funct3, addr, wdata,
        output done, rdata
    );

endinterface

// ==== common/rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

    // data word and register index
    typedef logic [`RV_XLEN-1:0]        word_t;
    typedef logic [`RV_REG_ADDR_W-1:0]  reg_addr_t;

    // byte addresses into instruction and data memory
    typedef logic [`RV_IMEM_ADDR_W-1:0] iaddr_t;
    typedef logic [`RV_DMEM_ADDR_W-1:0] daddr_t;

    // one write enable per byte lane
    typedef logic [3:0]                 byte_en_t;

    typedef logic [2:0]                 funct3_t;

    // one instruction in flight, one state per step
    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_mem_wait,
        st_write,
        st_halt
    } ctrl_state_t;

endpackage

// ==== common/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath widths
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_IMEM_ADDR_W  12
`define RV_DMEM_ADDR_W  12

// first fetch address after reset
`define RV_RESET_PC     12'h000

// major opcodes, instr[6:0]
`define RV_OP_ALU       7'b0110011
`define RV_OP_ALUI      7'b0010011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_SYSTEM    7'b1110011

`endif
